//--- filelist.f
cpuIsaPkg.sv
cpuPipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
accumCore.sv
tbAccumCore.sv

//--- Makefile
# Verilator simulation of the accumulator core testbench

VERILATOR ?= verilator
TOP ?= tbAccumCore
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tbAccumCore.sv
`timescale 1ns/100ps

module tbAccumCore
	import cpuIsaPkg::*;
();

	localparam int MemWords = 1024;
	localparam int ResetCycles = 4;
	localparam int StepLimit = 4000;
	localparam int RandomLength = 200;

	logic clk;
	logic arstN;
	logic [PcWidth-1:0] instrAddr;
	instrT instrData;
	logic [PcWidth-1:0] memAddr;
	logic [DataWidth-1:0] memWrData;
	logic memWrEn;
	logic [DataWidth-1:0] memRdData;

	instrT instrMem [0:MemWords-1];
	logic [DataWidth-1:0] dataMem [0:MemWords-1];
	logic [DataWidth-1:0] refMem [0:MemWords-1];
	// expected store trace of the running program
	logic [PcWidth-1:0] expAddr [$];
	logic [DataWidth-1:0] expData [$];

	logic [PcWidth-1:0] progPc;
	logic [PcWidth-1:0] haltAddr;
	int testId;
	int seenTestId;
	int storeIdx;
	int checkErrors;
	int budget;
	int watchCycles;
	int testsRun;
	int testsFailed;

	accumCore #(
		.ResetPc(10'd0)
	) accumCore_inst (
		.clk(clk),
		.arstN(arstN),
		.instrAddr(instrAddr),
		.instrData(instrData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrEn(memWrEn),
		.memRdData(memRdData)
	);

	// both memories answer in the same cycle
	assign instrData = instrMem[instrAddr];
	assign memRdData = dataMem[memAddr];

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// preset data, every address bit takes part
	function automatic logic [DataWidth-1:0] presetByte(input logic [PcWidth-1:0] addr);
		return addr[7:0] ^ addr[9:2] ^ 8'h3c;
	endfunction

	// data memory, refilled while reset is held
	initial begin
		for (int i = 0; i < MemWords; i++) begin
			dataMem[i] = presetByte(10'(i));
		end
		forever begin
			@(posedge clk);
			if (!arstN) begin
				for (int i = 0; i < MemWords; i++) begin
					dataMem[i] = presetByte(10'(i));
				end
			end else if (memWrEn) begin
				dataMem[memAddr] <= memWrData;
			end
		end
	end

	// ISA-level model, one instruction per step until the jump to itself
	function automatic void computeExpected();
		logic [PcWidth-1:0] pc;
		logic [PcWidth-1:0] nextPc;
		logic [PcWidth-1:0] relTarget;
		logic [PcWidth-1:0] info;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [DataWidth-1:0] c;
		logic taken;
		logic done;
		int steps;
		pc = '0;
		a = '0;
		b = '0;
		done = 1'b0;
		steps = 0;
		expAddr.delete();
		expData.delete();
		for (int i = 0; i < MemWords; i++) begin
			refMem[i] = presetByte(10'(i));
		end
		while (!done && steps < StepLimit) begin
			info = instrMem[pc].info;
			c = info[7:0];
			nextPc = pc + 10'd1;
			// sign-magnitude displacement from the next address
			relTarget = info[5] ? nextPc - {5'b0, info[4:0]} : nextPc + {5'b0, info[4:0]};
			taken = 1'b0;
			case (instrMem[pc].opcode)
				opLda: a = refMem[info];
				opLdb: b = refMem[info];
				opLdca: a = c;
				opLdcb: b = c;
				opSta: begin
					refMem[info] = a;
					expAddr.push_back(info);
					expData.push_back(a);
				end
				opStb: begin
					refMem[info] = b;
					expAddr.push_back(info);
					expData.push_back(b);
				end
				// register forms take A as first operand
				opAdda: a = a + b;
				opAddb: b = a + b;
				opAddca: a = a + c;
				opAddcb: b = b + c;
				opSuba: a = a - b;
				opSubb: b = a - b;
				opSubca: a = a - c;
				opSubcb: b = b - c;
				opAnda: a = a & b;
				opAndb: b = a & b;
				opAndca: a = a & c;
				opAndcb: b = b & c;
				opOra: a = a | b;
				opOrb: b = a | b;
				opOrca: a = a | c;
				opOrcb: b = b | c;
				opAsla: a = a << 1;
				opAsra: a = 8'($signed(a) >>> 1);
				opJmp: begin
					done = (info == pc);
					nextPc = info;
				end
				opBaeq: taken = (a == 8'h00);
				opBane: taken = (a != 8'h00);
				opBami: taken = a[7];
				opBapl: taken = !a[7];
				opBbeq: taken = (b == 8'h00);
				opBbne: taken = (b != 8'h00);
				opBbmi: taken = b[7];
				opBbpl: taken = !b[7];
				default: ;
			endcase
			if (taken) begin
				nextPc = relTarget;
			end
			pc = nextPc;
			steps++;
		end
		if (!done) begin
			$display("reference model did not reach the halting jump");
		end
	endfunction

	// compares every store strobe with the expected trace, in order
	initial begin
		seenTestId = 0;
		storeIdx = 0;
		checkErrors = 0;
		forever begin
			@(posedge clk);
			if (testId != seenTestId) begin
				seenTestId = testId;
				storeIdx = 0;
			end
			if (arstN && memWrEn) begin
				if (storeIdx >= expAddr.size()) begin
					$display("test %0d: unexpected store of %0h to address %0h at %0t",
						testId, memWrData, memAddr, $time);
					checkErrors++;
				end else begin
					if (memAddr != expAddr[storeIdx]) begin
						$display("FAILED %0t: test %0d store %0d address %0h, expected %0h",
							$time, testId, storeIdx, memAddr, expAddr[storeIdx]);
						checkErrors++;
					end
					if (memWrData != expData[storeIdx]) begin
						$display("FAILED %0t: test %0d store %0d data %0h, expected %0h",
							$time, testId, storeIdx, memWrData, expData[storeIdx]);
						checkErrors++;
					end
				end
				storeIdx++;
			end
		end
	end

	// budget grows with every program started
	initial begin
		watchCycles = 0;
		while (watchCycles <= budget) begin
			@(posedge clk);
			watchCycles++;
		end
		$display("timeout: program did not reach its halting jump after %0d cycles", watchCycles);
		$display("Verification failed");
		$finish;
	end

	task automatic eraseProgram();
		for (int i = 0; i < MemWords; i++) begin
			instrMem[i] = '0;
		end
		progPc = '0;
	endtask

	task automatic emit(input opcodeE op, input logic [PcWidth-1:0] info);
		instrMem[progPc] = {op, info};
		progPc = progPc + 10'd1;
	endtask

	// relative branch to an absolute target
	task automatic emitBranch(input opcodeE op, input int target);
		int disp;
		disp = target - (int'(progPc) + 1);
		emit(op, {4'b0000, disp < 0, 5'(disp < 0 ? -disp : disp)});
	endtask

	task automatic emitHalt();
		haltAddr = progPc;
		emit(opJmp, progPc);
	endtask

	task automatic runProgram(input string name);
		int errorsBefore;
		int haltSeen;
		logic missing;
		budget += (int'(progPc) + ResetCycles) * 8;
		computeExpected();
		@(negedge clk);
		arstN = 1'b0;
		testId++;
		errorsBefore = checkErrors;
		repeat (ResetCycles) @(negedge clk);
		arstN = 1'b1;
		// the halting jump loops every three cycles once it executes
		haltSeen = 0;
		while (haltSeen < 3) begin
			@(negedge clk);
			if (instrAddr == haltAddr) begin
				haltSeen++;
			end
		end
		missing = (storeIdx < expAddr.size());
		if (missing) begin
			$display("test %0d: only %0d of %0d expected stores were seen",
				testId, storeIdx, expAddr.size());
		end
		testsRun++;
		if (missing || checkErrors != errorsBefore) begin
			testsFailed++;
			$display("test %0d %s: fail", testId, name);
		end else begin
			$display("test %0d %s: pass, %0d stores", testId, name, storeIdx);
		end
		// hold the core while the next program is loaded
		arstN = 1'b0;
	endtask

	task automatic writeConstLoads();
		eraseProgram();
		emit(opLdca, 10'h05a);
		emit(opSta, 10'h010);
		emit(opLdcb, 10'h0a5);
		emit(opStb, 10'h011);
		emit(opLdca, 10'h0ff);
		emit(opSta, 10'h3ff);
		emit(opLdcb, 10'h000);
		emit(opStb, 10'h200);
		emit(opSta, 10'h201);
		emitHalt();
	endtask

	task automatic chainAluOps();
		eraseProgram();
		emit(opLdca, 10'h00a);
		emit(opLdcb, 10'h003);
		// A from memory stage, B from execute
		emit(opAdda, 10'h000);
		emit(opSta, 10'h060);
		emit(opSuba, 10'h000);
		emit(opSta, 10'h061);
		emit(opAddb, 10'h000);
		emit(opStb, 10'h062);
		emit(opAndca, 10'h00e);
		emit(opSta, 10'h063);
		emit(opOrcb, 10'h040);
		emit(opStb, 10'h064);
		emit(opSubcb, 10'h005);
		emit(opStb, 10'h065);
		emit(opSubb, 10'h000);
		emit(opStb, 10'h066);
		emit(opAndb, 10'h000);
		emit(opOra, 10'h000);
		emit(opSta, 10'h067);
		emit(opAddca, 10'h080);
		emit(opSubca, 10'h001);
		emit(opSta, 10'h068);
		emit(opAnda, 10'h000);
		emit(opOrb, 10'h000);
		emit(opAddcb, 10'h011);
		emit(opSta, 10'h069);
		emit(opStb, 10'h06a);
		emitHalt();
	endtask

	task automatic useLoadedBytes();
		eraseProgram();
		emit(opLda, 10'h155);
		emit(opAddca, 10'h001);
		emit(opSta, 10'h020);
		emit(opLdb, 10'h2aa);
		emit(opSubb, 10'h000);
		emit(opStb, 10'h021);
		emit(opLda, 10'h3c3);
		emit(opSta, 10'h022);
		emit(opLdb, 10'h011);
		emit(opAdda, 10'h000);
		emit(opSta, 10'h023);
		// read back bytes this program wrote
		emit(opLda, 10'h020);
		emit(opLdb, 10'h021);
		emit(opOrb, 10'h000);
		emit(opStb, 10'h024);
		emitHalt();
	endtask

	task automatic shiftAccumA();
		eraseProgram();
		emit(opLdca, 10'h096);
		emit(opAsra, 10'h000);
		emit(opSta, 10'h070);
		emit(opAsra, 10'h000);
		emit(opSta, 10'h071);
		emit(opAsla, 10'h000);
		emit(opSta, 10'h072);
		emit(opLdca, 10'h035);
		emit(opAsla, 10'h000);
		emit(opSta, 10'h073);
		emit(opAsra, 10'h000);
		emit(opAsla, 10'h000);
		emit(opAsla, 10'h000);
		emit(opSta, 10'h074);
		emit(opLdca, 10'h081);
		emit(opAsla, 10'h000);
		emit(opSta, 10'h075);
		emitHalt();
	endtask

	// stores at 3f0 and up sit in squashed slots
	task automatic takeBranches();
		logic [PcWidth-1:0] loopTop;
		eraseProgram();
		emit(opLdca, 10'h000);
		emit(opLdcb, 10'h085);
		emitBranch(opBaeq, int'(progPc) + 4);
		emit(opSta, 10'h3f0);
		emit(opSta, 10'h3f1);
		emit(opSta, 10'h3f2);
		emit(opLdca, 10'h005);
		emitBranch(opBaeq, int'(progPc) + 3);
		emit(opSta, 10'h040);
		emitBranch(opBane, int'(progPc) + 3);
		emit(opStb, 10'h3f3);
		emit(opStb, 10'h3f4);
		emitBranch(opBbmi, int'(progPc) + 3);
		emit(opSta, 10'h3f5);
		emit(opSta, 10'h3f6);
		emitBranch(opBbpl, int'(progPc) + 2);
		emit(opStb, 10'h041);
		emitBranch(opBami, int'(progPc) + 2);
		emit(opSta, 10'h042);
		emitBranch(opBapl, int'(progPc) + 3);
		emit(opSta, 10'h3f7);
		emit(opSta, 10'h3f8);
		emitBranch(opBbeq, int'(progPc) + 2);
		emit(opLdcb, 10'h003);
		// count B down with a backward branch
		loopTop = progPc;
		emit(opStb, 10'h050);
		emit(opSubcb, 10'h001);
		emitBranch(opBbne, int'(loopTop));
		emit(opStb, 10'h051);
		emitBranch(opBbeq, int'(progPc) + 3);
		emit(opStb, 10'h3f9);
		emit(opStb, 10'h3fa);
		emit(opJmp, progPc + 10'd3);
		emit(opSta, 10'h3fb);
		emit(opSta, 10'h3fc);
		emit(opSta, 10'h052);
		// B is zero and A is five here
		emitBranch(opBbmi, int'(progPc) + 2);
		emit(opStb, 10'h043);
		emitBranch(opBbpl, int'(progPc) + 3);
		emit(opStb, 10'h3fd);
		emit(opStb, 10'h3fe);
		emit(opLdca, 10'h000);
		emitBranch(opBane, int'(progPc) + 2);
		emit(opSta, 10'h044);
		// negative A for the remaining sign tests
		emit(opLdca, 10'h090);
		emitBranch(opBapl, int'(progPc) + 2);
		emit(opSta, 10'h045);
		emitBranch(opBami, int'(progPc) + 3);
		emit(opSta, 10'h3fd);
		emit(opSta, 10'h3fe);
		emitHalt();
	endtask

	task automatic fillRandomOps();
		opcodeE pick [24] = '{opNop, opLda, opLdb, opLdca, opLdcb, opSta, opStb,
			opAdda, opAddb, opAddca, opAddcb, opSuba, opSubb, opSubca, opSubcb,
			opAnda, opAndb, opAndca, opAndcb, opOra, opOrb, opOrca, opOrcb, opAsra};
		eraseProgram();
		for (int i = 0; i < RandomLength; i++) begin
			// shifts left ride on a reused slot now and then
			if ($urandom_range(0, 15) == 0) begin
				emit(opAsla, 10'($urandom));
			end else begin
				emit(pick[$urandom_range(0, 23)], 10'($urandom));
			end
		end
		emitHalt();
	endtask

	initial begin
		arstN = 1'b0;
		testId = 0;
		budget = 0;
		testsRun = 0;
		testsFailed = 0;
		haltAddr = '0;
		void'($urandom(32'hc78a));
		writeConstLoads();
		runProgram("constant loads and stores");
		chainAluOps();
		runProgram("dependent alu chains");
		useLoadedBytes();
		runProgram("memory loads used at once");
		shiftAccumA();
		runProgram("arithmetic shifts");
		takeBranches();
		runProgram("branches and jumps");
		fillRandomOps();
		runProgram("random straight-line program");
		$display("tests run %0d, passed %0d, failed %0d, check errors %0d",
			testsRun, testsRun - testsFailed, testsFailed, checkErrors);
		if (testsFailed == 0 && checkErrors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- accumCore.sv
`timescale 1ns/100ps

module accumCore
	import cpuIsaPkg::*, cpuPipePkg::*;
#(
	parameter logic [PcWidth-1:0] ResetPc = '0
) (
	input logic clk,
	input logic arstN,
	output logic [PcWidth-1:0] instrAddr,
	input instrT instrData,
	output logic [PcWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWrData,
	output logic memWrEn,
	input logic [DataWidth-1:0] memRdData
);

	ifIdT ifId;
	idExT idEx;
	exMemT exMem;
	wbT exFwd;
	wbT wb;
	logic branchTaken;
	logic [PcWidth-1:0] branchDir;

	fetchStage #(
		.ResetPc(ResetPc)
	) uFetch (
		.clk(clk),
		.arstN(arstN),
		.branchTaken(branchTaken),
		.branchDir(branchDir),
		.instrData(instrData),
		.instrAddr(instrAddr),
		.ifId(ifId)
	);

	// taken branch also kills the instruction in decode
	decodeStage uDecode (
		.clk(clk),
		.arstN(arstN),
		.ifId(ifId),
		.squash(branchTaken),
		.exFwd(exFwd),
		.wb(wb),
		.idEx(idEx)
	);

	executeStage uExecute (
		.clk(clk),
		.arstN(arstN),
		.idEx(idEx),
		.exMem(exMem),
		.exFwd(exFwd),
		.branchTaken(branchTaken),
		.branchDir(branchDir)
	);

	memoryStage uMemory (
		.exMem(exMem),
		.memRdData(memRdData),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memWrEn(memWrEn),
		.wb(wb)
	);

endmodule

//--- memoryStage.sv
`timescale 1ns/100ps

module memoryStage
	import cpuIsaPkg::*, cpuPipePkg::*;
(
	input exMemT exMem,
	input logic [DataWidth-1:0] memRdData,
	output logic [PcWidth-1:0] memAddr,
	output logic [DataWidth-1:0] memWrData,
	output logic memWrEn,
	output wbT wb
);

	logic isLoad;
	logic [DataWidth-1:0] wbValue;

	// data memory port, read data returns in the same cycle
	assign memAddr = exMem.address;
	assign memWrData = exMem.storeData;

	// one-cycle write strobe per live store
	assign memWrEn = exMem.valid && exMem.storeEn;

	// memory loads take read data
	assign isLoad = exMem.acumCtrl inside {loadMemoryA, loadMemoryB};

	// constant loads arrive as alu pass-through
	assign wbValue = isLoad ? memRdData : exMem.aluData;

	// decode writes the accumulators from this at the next edge
	assign wb = '{
		valid: exMem.valid,
		acumCtrl: exMem.acumCtrl,
		value: wbValue
	};

endmodule

//--- executeStage.sv
`timescale 1ns/100ps

module executeStage
	import cpuIsaPkg::*, cpuPipePkg::*;
(
	input logic clk,
	input logic arstN,
	input idExT idEx,
	output exMemT exMem,
	output wbT exFwd,
	output logic branchTaken,
	output logic [PcWidth-1:0] branchDir
);

	logic [DataWidth-1:0] oper1;
	logic [DataWidth-1:0] oper2;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] storeData;
	logic condMet;

	// operand muxes, accumulator or constant
	assign oper1 = idEx.operSel[1] ? idEx.acumA : idEx.constant;
	assign oper2 = idEx.operSel[0] ? idEx.acumB : idEx.constant;

	always_comb begin
		aluResult = '0;
		condMet = 1'b0;
		case (idEx.aluOp)
			aluPass: aluResult = oper1;
			aluAdd: aluResult = oper1 + oper2;
			aluSub: aluResult = oper1 - oper2;
			aluAnd: aluResult = oper1 & oper2;
			aluOr: aluResult = oper1 | oper2;
			// arithmetic shifts of A
			aluShl: aluResult = {oper1[DataWidth-2:0], 1'b0};
			aluShr: aluResult = {oper1[DataWidth-1], oper1[DataWidth-1:1]};
			// branch tests on A
			aluEqA: condMet = (oper1 == '0);
			aluNeA: condMet = (oper1 != '0);
			aluMiA: condMet = oper1[DataWidth-1];
			aluPlA: condMet = !oper1[DataWidth-1];
			// branch tests on B
			aluEqB: condMet = (oper2 == '0);
			aluNeB: condMet = (oper2 != '0);
			aluMiB: condMet = oper2[DataWidth-1];
			aluPlB: condMet = !oper2[DataWidth-1];
			aluJump: condMet = 1'b1;
			default: aluResult = oper1;
		endcase
	end

	// redirect only for a live instruction
	assign branchTaken = idEx.valid && condMet;
	assign branchDir = idEx.target;

	assign storeData = idEx.storeSel ? idEx.acumB : idEx.acumA;

	// result offered to decode in the same cycle
	assign exFwd = '{
		valid: idEx.valid,
		acumCtrl: idEx.acumCtrl,
		value: aluResult
	};

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exMem <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.aluData <= aluResult;
			exMem.acumCtrl <= idEx.acumCtrl;
			// target field carries the data address for loads and stores
			exMem.address <= idEx.target;
			exMem.storeEn <= idEx.storeEn;
			exMem.storeData <= storeData;
		end
	end

endmodule

//--- decodeStage.sv
`timescale 1ns/100ps

module decodeStage
	import cpuIsaPkg::*, cpuPipePkg::*;
(
	input logic clk,
	input logic arstN,
	input ifIdT ifId,
	input logic squash,
	input wbT exFwd,
	input wbT wb,
	output idExT idEx
);

	opcodeE opcode;
	instrInfoU info;
	operSelE operSel;
	aluOpE aluOp;
	acumCtrlE acumCtrl;
	logic isBranch;
	logic [DataWidth-1:0] constant;
	logic [PcWidth-1:0] relTarget;
	logic [DataWidth-1:0] acumA;
	logic [DataWidth-1:0] acumB;
	logic [DataWidth-1:0] fwdA;
	logic [DataWidth-1:0] fwdB;
	logic pendA;
	logic pendB;
	logic lateA;
	logic lateB;
	idExT idExD;
	idExT idExQ;

	function automatic logic writesA(acumCtrlE ctrl);
		return ctrl inside {loadConstantA, loadMemoryA, loadAluA};
	endfunction

	function automatic logic writesB(acumCtrlE ctrl);
		return ctrl inside {loadConstantB, loadMemoryB, loadAluB};
	endfunction

	assign opcode = ifId.instr.opcode;
	assign info = ifId.instr.info;

	// alu function
	always_comb begin
		case (opcode)
			opAdda, opAddb, opAddca, opAddcb: aluOp = aluAdd;
			// B - const done as B + (-const), operand 1 is the constant
			opSubcb: aluOp = aluAdd;
			opSuba, opSubb, opSubca: aluOp = aluSub;
			opAnda, opAndb, opAndca, opAndcb: aluOp = aluAnd;
			opOra, opOrb, opOrca, opOrcb: aluOp = aluOr;
			opAsla: aluOp = aluShl;
			opAsra: aluOp = aluShr;
			opBaeq: aluOp = aluEqA;
			opBane: aluOp = aluNeA;
			opBami: aluOp = aluMiA;
			opBapl: aluOp = aluPlA;
			opBbeq: aluOp = aluEqB;
			opBbne: aluOp = aluNeB;
			opBbmi: aluOp = aluMiB;
			opBbpl: aluOp = aluPlB;
			opJmp: aluOp = aluJump;
			// loads, stores, nop pass operand 1
			default: aluOp = aluPass;
		endcase
	end

	// operand select for the execute muxes
	always_comb begin
		case (opcode)
			opAddca, opSubca, opAndca, opOrca: operSel = selAcumAConstB;
			opAddcb, opSubcb, opAndcb, opOrcb: operSel = selConstAAcumB;
			opLda, opLdb, opLdca, opLdcb, opJmp, opNop: operSel = selConstants;
			// reg-reg ops, shifts and branch tests read both accumulators
			default: operSel = selAcumAB;
		endcase
	end

	// accumulator write control
	always_comb begin
		case (opcode)
			opLdca: acumCtrl = loadConstantA;
			opLdcb: acumCtrl = loadConstantB;
			opLda: acumCtrl = loadMemoryA;
			opLdb: acumCtrl = loadMemoryB;
			opAdda, opSuba, opAnda, opOra, opAddca, opSubca, opAndca, opOrca,
			opAsla, opAsra: acumCtrl = loadAluA;
			opAddb, opSubb, opAndb, opOrb, opAddcb, opSubcb, opAndcb, opOrcb:
				acumCtrl = loadAluB;
			default: acumCtrl = noLoad;
		endcase
	end

	assign isBranch = opcode inside {opBaeq, opBane, opBami, opBapl,
		opBbeq, opBbne, opBbmi, opBbpl};
	assign constant = (opcode == opSubcb) ? -info.constView.value : info.constView.value;

	// sign-magnitude displacement from the next pc
	assign relTarget = info.relView.sign ?
		ifId.pcNext - PcWidth'(info.relView.magnitude) :
		ifId.pcNext + PcWidth'(info.relView.magnitude);

	// forwarding, execute result wins over memory result
	always_comb begin
		fwdA = acumA;
		fwdB = acumB;
		if (wb.valid && writesA(wb.acumCtrl)) begin
			fwdA = wb.value;
		end
		if (wb.valid && writesB(wb.acumCtrl)) begin
			fwdB = wb.value;
		end
		if (exFwd.valid && writesA(exFwd.acumCtrl)) begin
			fwdA = exFwd.value;
		end
		if (exFwd.valid && writesB(exFwd.acumCtrl)) begin
			fwdB = exFwd.value;
		end
	end

	// memory load in execute has no data yet, patch it one cycle later
	assign pendA = exFwd.valid && (exFwd.acumCtrl == loadMemoryA);
	assign pendB = exFwd.valid && (exFwd.acumCtrl == loadMemoryB);

	always_comb begin
		idExD.valid = ifId.valid && !squash;
		idExD.acumA = fwdA;
		idExD.acumB = fwdB;
		idExD.constant = constant;
		idExD.operSel = operSel;
		idExD.aluOp = aluOp;
		idExD.acumCtrl = acumCtrl;
		// jmp and memory ops use the absolute address view
		idExD.target = isBranch ? relTarget : info.addrView;
		idExD.storeEn = opcode inside {opSta, opStb};
		idExD.storeSel = (opcode == opStb);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			idExQ <= '0;
			lateA <= 1'b0;
			lateB <= 1'b0;
		end else begin
			idExQ <= idExD;
			lateA <= pendA;
			lateB <= pendB;
		end
	end

	// load now sits in memory, its read data is on wb
	always_comb begin
		idEx = idExQ;
		if (lateA) begin
			idEx.acumA = wb.value;
		end
		if (lateB) begin
			idEx.acumB = wb.value;
		end
	end

	// single write point for both accumulators
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			acumA <= '0;
			acumB <= '0;
		end else if (wb.valid) begin
			if (writesA(wb.acumCtrl)) begin
				acumA <= wb.value;
			end
			if (writesB(wb.acumCtrl)) begin
				acumB <= wb.value;
			end
		end
	end

endmodule

//--- fetchStage.sv
`timescale 1ns/100ps

module fetchStage
	import cpuIsaPkg::*, cpuPipePkg::*;
#(
	parameter logic [PcWidth-1:0] ResetPc = '0
) (
	input logic clk,
	input logic arstN,
	input logic branchTaken,
	input logic [PcWidth-1:0] branchDir,
	input instrT instrData,
	output logic [PcWidth-1:0] instrAddr,
	output ifIdT ifId
);

	logic [PcWidth-1:0] pc;
	logic [PcWidth-1:0] pcInc;

	// instruction memory answers in the same cycle
	assign instrAddr = pc;
	assign pcInc = pc + PcWidth'(1);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= ResetPc;
			ifId <= '0;
		end else begin
			// taken branch in execute redirects the pc
			if (branchTaken) begin
				pc <= branchDir;
			end else begin
				pc <= pcInc;
			end
			// word fetched under a taken branch is dropped
			ifId.valid <= !branchTaken;
			ifId.instr <= instrData;
			ifId.pcNext <= pcInc;
		end
	end

endmodule

//--- cpuPipePkg.sv
package cpuPipePkg;

	import cpuIsaPkg::*;

	// fetch to decode
	typedef struct packed {
		logic valid;
		instrT instr;
		// fetch address plus one, base for relative branches
		logic [PcWidth-1:0] pcNext;
	} ifIdT;

	// decode to execute
	typedef struct packed {
		logic valid;
		// accumulators after forwarding
		logic [DataWidth-1:0] acumA;
		logic [DataWidth-1:0] acumB;
		logic [DataWidth-1:0] constant;
		operSelE operSel;
		aluOpE aluOp;
		acumCtrlE acumCtrl;
		// branch target or data-memory address
		logic [PcWidth-1:0] target;
		logic storeEn;
		// 0 stores A, 1 stores B
		logic storeSel;
	} idExT;

	// execute to memory
	typedef struct packed {
		logic valid;
		logic [DataWidth-1:0] aluData;
		acumCtrlE acumCtrl;
		logic [PcWidth-1:0] address;
		logic storeEn;
		logic [DataWidth-1:0] storeData;
	} exMemT;

	// accumulator write packet, also used for forwarding
	typedef struct packed {
		logic valid;
		acumCtrlE acumCtrl;
		logic [DataWidth-1:0] value;
	} wbT;

endpackage

//--- cpuIsaPkg.sv
package cpuIsaPkg;

	// datapath and address widths are fixed by the ISA
	localparam int DataWidth = 8;
	localparam int PcWidth = 10;

	// 6-bit opcodes, carry branches are not implemented
	typedef enum logic [5:0] {
		opNop = 6'h00,
		opLda = 6'h01,
		opLdb = 6'h02,
		opLdca = 6'h03,
		opLdcb = 6'h04,
		opSta = 6'h05,
		opStb = 6'h06,
		opAdda = 6'h07,
		opAddb = 6'h08,
		opAddca = 6'h09,
		opAddcb = 6'h0a,
		opSuba = 6'h0b,
		opSubb = 6'h0c,
		opSubca = 6'h0d,
		opSubcb = 6'h0e,
		opAnda = 6'h0f,
		opAndb = 6'h10,
		opAndca = 6'h11,
		opAndcb = 6'h12,
		opOra = 6'h13,
		opOrb = 6'h14,
		opOrca = 6'h15,
		opOrcb = 6'h16,
		opAsla = 6'h17,
		opAsra = 6'h18,
		opJmp = 6'h19,
		opBaeq = 6'h1a,
		opBane = 6'h1b,
		opBami = 6'h1c,
		opBapl = 6'h1d,
		opBbeq = 6'h1e,
		opBbne = 6'h1f,
		opBbmi = 6'h20,
		opBbpl = 6'h21
	} opcodeE;

	// constant view of the info field
	typedef struct packed {
		logic [1:0] spare;
		logic [DataWidth-1:0] value;
	} instrConstT;

	// relative branch view, sign plus 5-bit magnitude
	typedef struct packed {
		logic [3:0] spare;
		logic sign;
		logic [4:0] magnitude;
	} instrRelT;

	// one info word, read as constant, absolute address or displacement
	typedef union packed {
		instrConstT constView;
		logic [PcWidth-1:0] addrView;
		instrRelT relView;
	} instrInfoU;

	typedef struct packed {
		opcodeE opcode;
		instrInfoU info;
	} instrT;

	// accumulator write control
	typedef enum logic [2:0] {
		noLoad = 3'b000,
		loadConstantA = 3'b001,
		loadMemoryA = 3'b010,
		loadConstantB = 3'b011,
		loadMemoryB = 3'b100,
		loadAluA = 3'b101,
		loadAluB = 3'b110
	} acumCtrlE;

	// bit 1 picks A for operand 1, bit 0 picks B for operand 2
	typedef enum logic [1:0] {
		selConstants = 2'b00,
		selConstAAcumB = 2'b01,
		selAcumAConstB = 2'b10,
		selAcumAB = 2'b11
	} operSelE;

	// alu functions and branch tests
	typedef enum logic [3:0] {
		aluPass,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr,
		aluEqA,
		aluNeA,
		aluMiA,
		aluPlA,
		aluEqB,
		aluNeB,
		aluMiB,
		aluPlB,
		aluJump
	} aluOpE;

endpackage
